// ==== source/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

  localparam int xlen = 32;
  // tag 0 means no dependency, and no broadcast on a bus
  localparam int tag_width = 4;

  typedef logic [tag_width-1:0] tag_t;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt,
    op_sltu,
    op_beq,
    op_bne,
    op_blt,
    op_bge
  } op_t;

  typedef struct packed {
    op_t             op;
    logic            use_imm;
    tag_t            dest;
    tag_t            qj;
    tag_t            qk;
    logic [xlen-1:0] vj;
    logic [xlen-1:0] vk;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
  } issue_t;

  typedef struct packed {
    logic            valid;
    tag_t            tag;
    logic [xlen-1:0] value;
  } bcast_t;

  typedef struct packed {
    logic            valid;
    op_t             op;
    logic            use_imm;
    tag_t            dest;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
  } dispatch_t;

  typedef struct packed {
    logic            valid;
    tag_t            tag;
    logic [xlen-1:0] value;
    logic [xlen-1:0] next_pc;
  } result_t;

endpackage

`default_nettype wire

// ==== source/rs_select.sv ====
`default_nettype none

module rs_select #(
  parameter int depth = 8
) (
  input  logic [depth-1:0]                           busy,
  input  logic [depth-1:0]                           ready,
  output logic [((depth > 1) ? $clog2(depth) : 1)-1:0] free_index,
  output logic                                       free_found,
  output logic [((depth > 1) ? $clog2(depth) : 1)-1:0] ready_index,
  output logic                                       ready_found
);

  localparam int idx_width = (depth > 1) ? $clog2(depth) : 1;

  // scan from the top so the lowest index is the last one written
  always_comb begin
    free_index = '0;
    free_found = 1'b0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_index = idx_width'(i);
        free_found = 1'b1;
      end
    end
  end

  always_comb begin
    ready_index = '0;
    ready_found = 1'b0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (ready[i]) begin
        ready_index = idx_width'(i);
        ready_found = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rs_station.sv ====
`default_nettype none

module rs_station #(
  parameter int depth = 8
) (
  input  logic                                       clk,
  input  logic                                       is_any_reset,
  input  logic                                       flush,
  input  rs_pkg::issue_t                             issue,
  input  logic                                       issue_valid,
  input  rs_pkg::bcast_t                             lsb_bus,
  input  rs_pkg::result_t                            cdb,
  input  logic [((depth > 1) ? $clog2(depth) : 1)-1:0] free_index,
  input  logic                                       free_found,
  input  logic [((depth > 1) ? $clog2(depth) : 1)-1:0] ready_index,
  input  logic                                       ready_found,
  output logic [depth-1:0]                           busy,
  output logic [depth-1:0]                           ready,
  output rs_pkg::dispatch_t                          dispatch,
  output logic                                       credit_return
);

  localparam int idx_width = (depth > 1) ? $clog2(depth) : 1;

  rs_pkg::op_t                op_q     [depth];
  logic                       use_imm_q[depth];
  rs_pkg::tag_t               dest_q   [depth];
  rs_pkg::tag_t               qj_q     [depth];
  rs_pkg::tag_t               qk_q     [depth];
  logic [rs_pkg::xlen-1:0]    vj_q     [depth];
  logic [rs_pkg::xlen-1:0]    vk_q     [depth];
  logic [rs_pkg::xlen-1:0]    imm_q    [depth];
  logic [rs_pkg::xlen-1:0]    pc_q     [depth];

  rs_pkg::bcast_t             cdb_bus;
  rs_pkg::tag_t               issue_qj;
  rs_pkg::tag_t               issue_qk;
  logic [rs_pkg::xlen-1:0]    issue_vj;
  logic [rs_pkg::xlen-1:0]    issue_vk;
  logic                       do_issue;
  logic [idx_width-1:0]       wr_index;

  function automatic logic hit(rs_pkg::tag_t q, rs_pkg::bcast_t bus);
    return bus.valid && (bus.tag != '0) && (bus.tag == q);
  endfunction

  // the CDB seen as a plain broadcast for wakeup
  assign cdb_bus = '{valid: cdb.valid, tag: cdb.tag, value: cdb.value};

  assign do_issue = issue_valid && free_found && !flush;
  assign wr_index = free_index;

  // same-cycle bypass for the incoming operands with the CDB taking priority
  always_comb begin
    issue_qj = issue.qj;
    issue_vj = issue.vj;
    if (hit(issue.qj, cdb_bus)) begin
      issue_qj = '0;
      issue_vj = cdb_bus.value;
    end else if (hit(issue.qj, lsb_bus)) begin
      issue_qj = '0;
      issue_vj = lsb_bus.value;
    end
  end

  always_comb begin
    issue_qk = issue.qk;
    issue_vk = issue.vk;
    if (hit(issue.qk, cdb_bus)) begin
      issue_qk = '0;
      issue_vk = cdb_bus.value;
    end else if (hit(issue.qk, lsb_bus)) begin
      issue_qk = '0;
      issue_vk = lsb_bus.value;
    end
  end

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      ready[i] = busy[i] && (qj_q[i] == '0) && (qk_q[i] == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (is_any_reset || flush) begin
      busy <= '0;
    end else begin
      if (ready_found) begin
        busy[ready_index] <= 1'b0;
      end
      if (do_issue) begin
        busy[wr_index] <= 1'b1;
      end
    end
  end

  // operand storage, wakeup and issue write
  always_ff @(posedge clk) begin
    for (int i = 0; i < depth; i++) begin
      if (busy[i]) begin
        if (hit(qj_q[i], cdb_bus)) begin
          qj_q[i] <= '0;
          vj_q[i] <= cdb_bus.value;
        end else if (hit(qj_q[i], lsb_bus)) begin
          qj_q[i] <= '0;
          vj_q[i] <= lsb_bus.value;
        end
        if (hit(qk_q[i], cdb_bus)) begin
          qk_q[i] <= '0;
          vk_q[i] <= cdb_bus.value;
        end else if (hit(qk_q[i], lsb_bus)) begin
          qk_q[i] <= '0;
          vk_q[i] <= lsb_bus.value;
        end
      end
    end
    if (do_issue) begin
      op_q[wr_index]      <= issue.op;
      use_imm_q[wr_index] <= issue.use_imm;
      dest_q[wr_index]    <= issue.dest;
      qj_q[wr_index]      <= issue_qj;
      qk_q[wr_index]      <= issue_qk;
      vj_q[wr_index]      <= issue_vj;
      vk_q[wr_index]      <= issue_vk;
      imm_q[wr_index]     <= issue.imm;
      pc_q[wr_index]      <= issue.pc;
    end
  end

  // dispatch register that returns one credit per dispatched entry
  always_ff @(posedge clk) begin
    if (is_any_reset || flush) begin
      dispatch.valid <= 1'b0;
      credit_return  <= 1'b0;
    end else begin
      dispatch.valid <= ready_found;
      credit_return  <= ready_found;
    end
    dispatch.op      <= op_q[ready_index];
    dispatch.use_imm <= use_imm_q[ready_index];
    dispatch.dest    <= dest_q[ready_index];
    dispatch.a       <= vj_q[ready_index];
    dispatch.b       <= vk_q[ready_index];
    dispatch.imm     <= imm_q[ready_index];
    dispatch.pc      <= pc_q[ready_index];
  end

  // the issuer's credits must keep it off a full station
  a_issue_has_room: assert property (
    @(posedge clk) disable iff (is_any_reset || flush)
    issue_valid |-> free_found
  );

  a_dispatch_resolved: assert property (
    @(posedge clk) disable iff (is_any_reset)
    ready_found |-> busy[ready_index] && (qj_q[ready_index] == '0) && (qk_q[ready_index] == '0)
  );

endmodule

`default_nettype wire

// ==== source/alu_exec.sv ====
`default_nettype none

module alu_exec (
  input  logic              clk,
  input  logic              is_any_reset,
  input  logic              flush,
  input  rs_pkg::dispatch_t dispatch,
  output rs_pkg::result_t   cdb
);

  localparam int shamt_width = $clog2(rs_pkg::xlen);

  logic [rs_pkg::xlen-1:0] operand_b;
  logic [rs_pkg::xlen-1:0] value;
  logic [rs_pkg::xlen-1:0] target;
  logic [rs_pkg::xlen-1:0] next_pc;
  logic                    taken;
  logic                    is_branch;

  assign operand_b = dispatch.use_imm ? dispatch.imm : dispatch.b;
  assign target    = dispatch.pc + dispatch.imm;

  // stage one where branches compare the two register operands
  always_comb begin
    value     = '0;
    taken     = 1'b0;
    is_branch = 1'b0;
    case (dispatch.op)
      rs_pkg::op_add:  value = dispatch.a + operand_b;
      rs_pkg::op_sub:  value = dispatch.a - operand_b;
      rs_pkg::op_and:  value = dispatch.a & operand_b;
      rs_pkg::op_or:   value = dispatch.a | operand_b;
      rs_pkg::op_xor:  value = dispatch.a ^ operand_b;
      rs_pkg::op_sll:  value = dispatch.a << operand_b[shamt_width-1:0];
      rs_pkg::op_srl:  value = dispatch.a >> operand_b[shamt_width-1:0];
      rs_pkg::op_slt:  value = {{(rs_pkg::xlen-1){1'b0}}, $signed(dispatch.a) < $signed(operand_b)};
      rs_pkg::op_sltu: value = {{(rs_pkg::xlen-1){1'b0}}, dispatch.a < operand_b};
      rs_pkg::op_beq: begin
        is_branch = 1'b1;
        taken     = dispatch.a == dispatch.b;
      end
      rs_pkg::op_bne: begin
        is_branch = 1'b1;
        taken     = dispatch.a != dispatch.b;
      end
      rs_pkg::op_blt: begin
        is_branch = 1'b1;
        taken     = $signed(dispatch.a) < $signed(dispatch.b);
      end
      rs_pkg::op_bge: begin
        is_branch = 1'b1;
        taken     = $signed(dispatch.a) >= $signed(dispatch.b);
      end
      default: value = '0;
    endcase
    if (is_branch) begin
      value = {{(rs_pkg::xlen-1){1'b0}}, taken};
    end
  end

  assign next_pc = taken ? target : dispatch.pc + rs_pkg::xlen'(4);

  // stage two
  always_ff @(posedge clk) begin
    if (is_any_reset || flush) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= dispatch.valid;
    end
    cdb.tag     <= dispatch.dest;
    cdb.value   <= value;
    cdb.next_pc <= next_pc;
  end

  // a tag 0 result would match no reorder-buffer entry
  a_cdb_tag_nonzero: assert property (
    @(posedge clk) disable iff (is_any_reset)
    cdb.valid |-> cdb.tag != '0
  );

endmodule

`default_nettype wire

// ==== source/rs_top.sv ====
`default_nettype none

module rs_top #(
  parameter int depth = 8
) (
  input  logic            clk,
  input  logic            is_any_reset,
  input  logic            flush,
  input  rs_pkg::issue_t  issue,
  input  logic            issue_valid,
  input  rs_pkg::bcast_t  lsb_bus,
  output rs_pkg::result_t cdb,
  output logic            credit_return
);

  localparam int idx_width = (depth > 1) ? $clog2(depth) : 1;

  logic [depth-1:0]     busy;
  logic [depth-1:0]     ready;
  logic [idx_width-1:0] free_index;
  logic                 free_found;
  logic [idx_width-1:0] ready_index;
  logic                 ready_found;
  rs_pkg::dispatch_t    dispatch;

  rs_station #(
    .depth(depth)
  ) station_inst (
    .clk          (clk),
    .is_any_reset (is_any_reset),
    .flush        (flush),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .lsb_bus      (lsb_bus),
    .cdb          (cdb),
    .free_index   (free_index),
    .free_found   (free_found),
    .ready_index  (ready_index),
    .ready_found  (ready_found),
    .busy         (busy),
    .ready        (ready),
    .dispatch     (dispatch),
    .credit_return(credit_return)
  );

  rs_select #(
    .depth(depth)
  ) select_inst (
    .busy       (busy),
    .ready      (ready),
    .free_index (free_index),
    .free_found (free_found),
    .ready_index(ready_index),
    .ready_found(ready_found)
  );

  // cdb goes out and also back into the station as a wakeup bus
  alu_exec exec_inst (
    .clk         (clk),
    .is_any_reset(is_any_reset),
    .flush       (flush),
    .dispatch    (dispatch),
    .cdb         (cdb)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_rs_top.sv ====
`default_nettype none

module tb_rs_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth = 8;
  localparam int n_issue = 300;
  localparam int flush_at = 150;
  localparam int cycle_limit = 40 * n_issue + 400;

  logic            clk;
  logic            is_any_reset;
  logic            flush;
  rs_pkg::issue_t  issue;
  logic            issue_valid;
  rs_pkg::bcast_t  lsb_bus;
  rs_pkg::result_t cdb;
  logic            credit_return;

  // model state indexed by reorder-buffer tag
  logic        allocated[16];
  logic        is_load[16];
  logic        outstanding[16];
  logic        bcast_now[16];
  int          load_due[16];
  logic [31:0] tag_value[16];
  rs_pkg::op_t op_m[16];
  logic        use_imm_m[16];
  logic [31:0] a_m[16];
  logic [31:0] b_m[16];
  int          qa_m[16];
  int          qb_m[16];
  logic [31:0] imm_m[16];
  logic [31:0] pc_m[16];

  int credits = depth;
  int issued = 0;
  int results = 0;
  int dropped = 0;
  int stalls = 0;
  int mismatches = 0;
  int other_errors = 0;
  int cycle = 0;
  bit flushed = 0;

  rs_top #(
    .depth(depth)
  ) rs_top_inst (
    .clk          (clk),
    .is_any_reset (is_any_reset),
    .flush        (flush),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .lsb_bus      (lsb_bus),
    .cdb          (cdb),
    .credit_return(credit_return)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle > cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d ops issued", cycle, issued, n_issue);
      $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] rand_value();
    return ($urandom % 2 == 1) ? $urandom % 8 : $urandom;
  endfunction

  function automatic logic branch_taken(rs_pkg::op_t op, logic [31:0] a, logic [31:0] b);
    case (op)
      rs_pkg::op_beq: return a == b;
      rs_pkg::op_bne: return a != b;
      rs_pkg::op_blt: return $signed(a) < $signed(b);
      rs_pkg::op_bge: return $signed(a) >= $signed(b);
      default:        return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] expected_value(int t);
    logic [31:0] y;
    y = use_imm_m[t] ? imm_m[t] : b_m[t];
    case (op_m[t])
      rs_pkg::op_add:  return a_m[t] + y;
      rs_pkg::op_sub:  return a_m[t] - y;
      rs_pkg::op_and:  return a_m[t] & y;
      rs_pkg::op_or:   return a_m[t] | y;
      rs_pkg::op_xor:  return a_m[t] ^ y;
      rs_pkg::op_sll:  return a_m[t] << y[4:0];
      rs_pkg::op_srl:  return a_m[t] >> y[4:0];
      rs_pkg::op_slt:  return ($signed(a_m[t]) < $signed(y)) ? 32'd1 : 32'd0;
      rs_pkg::op_sltu: return (a_m[t] < y) ? 32'd1 : 32'd0;
      default:         return branch_taken(op_m[t], a_m[t], b_m[t]) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] expected_next_pc(int t);
    if (branch_taken(op_m[t], a_m[t], b_m[t])) begin
      return pc_m[t] + imm_m[t];
    end
    return pc_m[t] + 32'd4;
  endfunction

  function automatic bit work_left();
    for (int t = 1; t < 16; t++) begin
      if (outstanding[t] || is_load[t]) return 1'b1;
    end
    return credits != depth;
  endfunction

  // wake every model operand that waits on this tag
  task automatic broadcast(input int t, input logic [31:0] v);
    bcast_now[t] = 1'b1;
    tag_value[t] = v;
    for (int k = 1; k < 16; k++) begin
      if (outstanding[k] && qa_m[k] == t) begin
        a_m[k] = v;
        qa_m[k] = 0;
      end
      if (outstanding[k] && qb_m[k] == t) begin
        b_m[k] = v;
        qb_m[k] = 0;
      end
    end
  endtask

  task automatic check_result();
    int t;
    logic [31:0] exp_v;
    logic [31:0] exp_pc;
    t = int'(cdb.tag);
    if (!outstanding[t]) begin
      other_errors++;
      $display("%0t: cdb carries tag %0d with no outstanding op", $time, t);
    end else if (qa_m[t] != 0 || qb_m[t] != 0) begin
      other_errors++;
      $display("%0t: tag %0d completed before its operands were broadcast", $time, t);
    end else begin
      exp_v = expected_value(t);
      exp_pc = expected_next_pc(t);
      if (cdb.value !== exp_v) begin
        mismatches++;
        $display("mismatch at %0t: tag %0d value %h, expected %h", $time, t, cdb.value, exp_v);
      end
      if (cdb.next_pc !== exp_pc) begin
        mismatches++;
        $display("mismatch at %0t: tag %0d next_pc %h, expected %h",
                 $time, t, cdb.next_pc, exp_pc);
      end
      outstanding[t] = 1'b0;
      results++;
      broadcast(t, exp_v);
    end
  endtask

  // at most one load per cycle with the lowest due tag first
  task automatic drive_load();
    for (int t = 1; t < 16; t++) begin
      if (is_load[t] && load_due[t] <= cycle) begin
        lsb_bus = '{valid: 1'b1, tag: rs_pkg::tag_t'(t), value: rand_value()};
        broadcast(t, lsb_bus.value);
        return;
      end
    end
  endtask

  // value, tag of a pending op or load, or a freshly reserved load tag
  task automatic pick_source(output int q, output logic [31:0] v);
    int kind;
    int cand[$];
    kind = $urandom % 3;
    q = 0;
    v = rand_value();
    for (int t = 1; t < 16; t++) begin
      if ((kind == 1) == allocated[t]) cand.push_back(t);
    end
    if (kind == 1 && cand.size() > 0) begin
      q = cand[$urandom % cand.size()];
    end else if (kind == 2 && cand.size() > 1) begin
      q = cand[$urandom % cand.size()];
      allocated[q] = 1'b1;
      is_load[q] = 1'b1;
      load_due[q] = cycle + 1 + $urandom % 10;
    end
  endtask

  task automatic try_issue();
    int qj;
    int qk;
    int opn;
    logic uimm;
    logic [31:0] vj;
    logic [31:0] vk;
    int dest;
    int free_t[$];
    if ($urandom % 100 >= 85) return;
    if (credits == 0) begin
      stalls++;
      return;
    end
    opn = $urandom % 13;
    uimm = (opn < 9) && ($urandom % 2 == 1);
    pick_source(qj, vj);
    qk = 0;
    vk = rand_value();
    if (!uimm) pick_source(qk, vk);
    for (int t = 1; t < 16; t++) begin
      if (!allocated[t]) free_t.push_back(t);
    end
    if (free_t.size() == 0) return;
    dest = free_t[$urandom % free_t.size()];
    issue.op = rs_pkg::op_t'(4'(opn));
    issue.use_imm = uimm;
    issue.dest = rs_pkg::tag_t'(dest);
    issue.qj = rs_pkg::tag_t'(qj);
    issue.qk = rs_pkg::tag_t'(qk);
    issue.vj = vj;
    issue.vk = vk;
    issue.imm = ($urandom % 2 == 1) ? $urandom % 64 : $urandom;
    issue.pc = $urandom & 32'hffff_fffc;
    issue_valid = 1'b1;
    credits--;
    issued++;
    allocated[dest] = 1'b1;
    outstanding[dest] = 1'b1;
    op_m[dest] = issue.op;
    use_imm_m[dest] = uimm;
    imm_m[dest] = issue.imm;
    pc_m[dest] = issue.pc;
    // a tag broadcast in this very cycle is taken by the bypass
    qa_m[dest] = (qj != 0 && !bcast_now[qj]) ? qj : 0;
    a_m[dest] = (qj != 0 && bcast_now[qj]) ? tag_value[qj] : vj;
    qb_m[dest] = (qk != 0 && !bcast_now[qk]) ? qk : 0;
    b_m[dest] = (qk != 0 && bcast_now[qk]) ? tag_value[qk] : vk;
  endtask

  task automatic clear_model();
    for (int t = 0; t < 16; t++) begin
      if (outstanding[t]) dropped++;
      allocated[t] = 1'b0;
      is_load[t] = 1'b0;
      outstanding[t] = 1'b0;
      bcast_now[t] = 1'b0;
    end
    credits = depth;
  endtask

  task automatic step(input bit allow_issue);
    issue_valid = 1'b0;
    lsb_bus = '0;
    flush = 1'b0;
    if (credit_return) begin
      credits++;
      if (credits > depth) begin
        other_errors++;
        $display("%0t: credit_return pushed the credit count to %0d", $time, credits);
      end
    end
    if (cdb.valid) check_result();
    if (allow_issue && !flushed && issued == flush_at) begin
      flush = 1'b1;
      flushed = 1'b1;
      clear_model();
    end else begin
      drive_load();
      if (allow_issue) try_issue();
    end
    // tags broadcast this cycle go back to the pool
    for (int t = 1; t < 16; t++) begin
      if (bcast_now[t]) begin
        allocated[t] = 1'b0;
        is_load[t] = 1'b0;
        bcast_now[t] = 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(75));
    is_any_reset = 1'b1;
    flush = 1'b0;
    issue = '0;
    issue_valid = 1'b0;
    lsb_bus = '0;
    clear_model();
    dropped = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    is_any_reset = 1'b0;
    while (issued < n_issue) begin
      @(negedge clk);
      step(1'b1);
    end
    while (work_left()) begin
      @(negedge clk);
      step(1'b0);
    end
    repeat (6) begin
      @(negedge clk);
      step(1'b0);
    end
    if (credits != depth) begin
      other_errors++;
      $display("credit count is %0d after drain, expected %0d", credits, depth);
    end
    if (results + dropped != issued) begin
      other_errors++;
      $display("%0d ops issued but %0d results and %0d flushed", issued, results, dropped);
    end
    if (stalls == 0) begin
      other_errors++;
      $display("issuer never ran out of credits");
    end
    $display("errors: %0d mismatches, %0d other (%0d issued, %0d results, %0d stalls)",
             mismatches, other_errors, issued, results, stalls);
    if (mismatches == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
source/rs_pkg.sv
source/rs_select.sv
source/rs_station.sv
source/alu_exec.sv
source/rs_top.sv
testbench/tb_rs_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the reservation station testbench with Verilator, run it and scan the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_rs_top -Mdir "$obj" -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$obj/Vtb_rs_top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" "$log"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $log"
exit 1
